//--- hw/tl_a_decoder.sv
////////////////////////////////////////////////////////////
// A-channel capture with range, size and mask checks
// Holds one checked request for the responder
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tl_a_decoder #(
    parameter int MEM_BYTES = 1024  // Memory depth in bytes
) (
    input  logic                  clk,
    input  logic                  reset,

    // A channel
    input  logic                  a_valid,
    output logic                  a_ready,
    input  tl_mem_pkg::tl_a_req_t a_req,

    // Checked request towards the responder
    output logic                  req_valid,
    output tl_mem_pkg::mem_req_t  req,
    input  logic                  req_take
);

    import tl_mem_pkg::*;

    logic              a_fire;       // A beat transfers this edge
    logic              is_read;
    logic              size_bad;
    logic              range_bad;
    logic              mask_ok;
    logic              hold_next;    // Holding register full after this edge
    logic [XLEN:0]     addr_limit;   // One bit wider to survive underflow

    assign a_fire  = a_valid && a_ready;
    assign is_read = (a_req.opcode == GET);

    ////////////////////////////////////////////////////////////
    // Request checks
    ////////////////////////////////////////////////////////////

    assign size_bad   = (a_req.size > SIZE_WORD);  // No double or quad words
    assign addr_limit = (XLEN + 1)'(MEM_BYTES) - (XLEN + 1)'(tl_size_bytes(a_req.size));
    assign range_bad  = ({1'b0, a_req.address} > addr_limit);

    // Legal lane patterns per size
    always_comb begin
        case (a_req.size)
            SIZE_BYTE: mask_ok = $onehot(a_req.mask);
            SIZE_HALF: mask_ok = (a_req.mask == 4'b0011) || (a_req.mask == 4'b1100);
            SIZE_WORD: mask_ok = (a_req.mask == {LANES{1'b1}});
            default:   mask_ok = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Holding register
    ////////////////////////////////////////////////////////////

    // Stays full until the responder takes it
    assign hold_next = (req_valid && !req_take) || a_fire;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_valid <= 1'b0;
            a_ready   <= 1'b0;           // Closed while in reset
        end else begin
            req_valid <= hold_next;
            a_ready   <= !hold_next;     // Open again on the take edge
        end
    end

    // Payload only loads on a transfer
    always_ff @(posedge clk) begin
        if (a_fire) begin
            req <= '{
                address: a_req.address,
                size:    a_req.size,
                source:  a_req.source,
                is_read: is_read,
                wdata:   a_req.data,
                denied:  size_bad || range_bad || (!is_read && !mask_ok)
            };
        end
    end

    // A stalled A beat keeps its valid and payload until the transfer
    a_req_held: assert property (
        @(posedge clk) disable iff (reset)
        a_valid && !a_ready |=> a_valid && $stable(a_req)
    );

endmodule

//--- hw/tl_byte_store.sv
////////////////////////////////////////////////////////////
// Byte-wide memory array
// Four-cycle read and write bursts, one byte lane per cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tl_byte_store #(
    parameter int MEM_BYTES = 1024  // Array depth
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mem_start,  // One-cycle pulse
    input  logic                        mem_write,
    input  logic [tl_mem_pkg::XLEN-1:0] mem_addr,
    input  logic [tl_mem_pkg::XLEN-1:0] mem_wdata,
    output logic [tl_mem_pkg::XLEN-1:0] mem_rdata,
    output logic                        mem_done    // One-cycle pulse
);

    import tl_mem_pkg::*;

    localparam int IDX_W  = $clog2(MEM_BYTES);
    localparam int PART_W = $clog2(LANES);

    logic [7:0]        mem_array [0:MEM_BYTES-1];  // One byte per entry

    logic              busy;
    logic [PART_W-1:0] part;        // Lane being moved
    logic [XLEN-1:0]   base_addr;   // Latched burst address
    logic [XLEN-1:0]   wr_data;     // Latched burst data
    logic              wr_en;       // Burst direction
    logic [XLEN-1:0]   part_addr;
    logic              part_ok;
    logic [IDX_W-1:0]  idx;

    assign part_addr = base_addr + XLEN'(part);
    assign part_ok   = (part_addr < MEM_BYTES);  // Tail of a short access may run past the end
    assign idx       = part_addr[IDX_W-1:0];

    ////////////////////////////////////////////////////////////
    // Burst control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            part     <= '0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;                    // Pulse by default
            if (mem_start) begin
                busy <= 1'b1;
                part <= '0;
            end else if (busy) begin
                part <= part + 1'b1;
                if (part == PART_W'(LANES - 1)) begin
                    busy     <= 1'b0;
                    mem_done <= 1'b1;            // Fourth edge after start
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Array access
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_start) begin
            base_addr <= mem_addr;
            wr_data   <= mem_wdata;
            wr_en     <= mem_write;
        end
        if (busy) begin
            if (wr_en) begin
                if (part_ok) begin
                    mem_array[idx] <= wr_data[8*part +: 8];  // Little-endian lane k
                end
            end else begin
                mem_rdata[8*part +: 8] <= part_ok ? mem_array[idx] : 8'h00;
            end
        end
    end

    // Responder may only start a burst on an idle store
    start_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        busy |-> !mem_start
    );

endmodule

//--- hw/tl_d_responder.sv
////////////////////////////////////////////////////////////
// Access sequencer with write merge
// Drives the store and holds the D-channel response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tl_d_responder (
    input  logic                        clk,
    input  logic                        reset,

    // Checked request from the decoder
    input  logic                        req_valid,
    input  tl_mem_pkg::mem_req_t        req,
    output logic                        req_take,

    // Store port
    output logic                        mem_start,
    output logic                        mem_write,
    output logic [tl_mem_pkg::XLEN-1:0] mem_addr,
    output logic [tl_mem_pkg::XLEN-1:0] mem_wdata,
    input  logic [tl_mem_pkg::XLEN-1:0] mem_rdata,
    input  logic                        mem_done,

    // D channel
    output logic                        d_valid,
    output tl_mem_pkg::tl_d_rsp_t       d_rsp,
    input  logic                        d_ready
);

    import tl_mem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,          // Four-byte read burst
        MERGE,          // New bytes over fetched ones
        WRITE_BACK,     // Four-byte write burst
        RESPOND_WAIT    // Response held until d_ready
    } rsp_state_t;

    rsp_state_t       state;
    mem_req_t         cur;        // Request in progress
    logic [XLEN-1:0]  merged;     // Write-back data
    logic [LANES-1:0] cur_lanes;  // Lanes written by the current request

    // Lanes covered by a transfer of this size
    function automatic logic [LANES-1:0] size_lanes(input tl_size_t size);
        logic [LANES-1:0] lanes;
        for (int k = 0; k < LANES; k++) begin
            lanes[k] = (k < tl_size_bytes(size));
        end
        return lanes;
    endfunction

    // D beat for a finished request
    function automatic tl_d_rsp_t build_rsp(input mem_req_t r, input logic [XLEN-1:0] rd);
        tl_d_rsp_t        rsp;
        logic [LANES-1:0] lanes;
        lanes      = size_lanes(r.size);
        rsp.size   = r.size;
        rsp.source = r.source;
        rsp.denied = r.denied;
        rsp.param  = r.denied ? PARAM_ERROR : PARAM_OK;
        rsp.data   = '0;
        if (r.denied) begin
            rsp.opcode = ACCESS_ACK_ERROR;
        end else if (r.is_read) begin
            rsp.opcode = ACCESS_ACK_DATA;
            for (int k = 0; k < LANES; k++) begin
                if (lanes[k]) rsp.data[8*k +: 8] = rd[8*k +: 8];  // Zero-extended
            end
        end else begin
            rsp.opcode = ACCESS_ACK;
        end
        return rsp;
    endfunction

    assign req_take  = (state == IDLE) && req_valid;  // One cycle, state leaves IDLE
    assign cur_lanes = size_lanes(cur.size);

    // Low size-many lanes come from the write data
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            merged[8*k +: 8] = cur_lanes[k] ? cur.wdata[8*k +: 8]
                                            : mem_rdata[8*k +: 8];
        end
    end

    ////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            d_valid   <= 1'b0;
            mem_start <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            mem_start <= 1'b0;
            case (state)
                IDLE: if (req_take) begin
                    if (req.denied) begin
                        d_valid <= 1'b1;     // Memory left untouched
                        state   <= RESPOND_WAIT;
                    end else begin
                        mem_start <= 1'b1;   // Reads and writes both fetch first
                        mem_write <= 1'b0;
                        state     <= FETCH;
                    end
                end
                FETCH: if (mem_done) begin
                    if (cur.is_read) begin
                        d_valid <= 1'b1;
                        state   <= RESPOND_WAIT;
                    end else begin
                        state <= MERGE;
                    end
                end
                MERGE: begin
                    mem_start <= 1'b1;
                    mem_write <= 1'b1;
                    state     <= WRITE_BACK;
                end
                WRITE_BACK: if (mem_done) begin
                    d_valid <= 1'b1;
                    state   <= RESPOND_WAIT;
                end
                RESPOND_WAIT: if (d_ready) begin
                    d_valid <= 1'b0;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload side of the sequencer
    always_ff @(posedge clk) begin
        case (state)
            IDLE: if (req_take) begin
                cur      <= req;
                mem_addr <= req.address;
                if (req.denied) d_rsp <= build_rsp(req, '0);
            end
            FETCH:      if (mem_done && cur.is_read) d_rsp <= build_rsp(cur, mem_rdata);
            MERGE: begin
                mem_addr  <= cur.address;
                mem_wdata <= merged;
            end
            WRITE_BACK: if (mem_done) d_rsp <= build_rsp(cur, '0);
            default: ;
        endcase
    end

    // Response frozen under back-pressure
    d_rsp_held: assert property (
        @(posedge clk) disable iff (reset)
        d_valid && !d_ready |=> d_valid && $stable(d_rsp)
    );

endmodule

//--- hw/tl_mem_pkg.sv
////////////////////////////////////////////////////////////
// Shared TileLink-UL definitions for the byte memory
// Opcodes, sizes, D params, widths and the stage structs
////////////////////////////////////////////////////////////

package tl_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN      = 32;        // Bus data width
    localparam int LANES     = XLEN / 8;  // Byte lanes per beat
    localparam int SID_WIDTH = 2;         // Source ID width

    ////////////////////////////////////////////////////////////
    // Opcodes and sizes
    ////////////////////////////////////////////////////////////

    // A and D opcodes share one encoding space, so no enum here
    typedef logic [2:0] tl_opcode_t;

    localparam tl_opcode_t PUT_FULL_DATA    = 3'b000;  // A channel write
    localparam tl_opcode_t GET              = 3'b100;  // A channel read
    localparam tl_opcode_t ACCESS_ACK       = 3'b000;  // D write ack
    localparam tl_opcode_t ACCESS_ACK_DATA  = 3'b001;  // D read ack with data
    localparam tl_opcode_t ACCESS_ACK_ERROR = 3'b111;  // D error response

    // Log2 of the transfer size in bytes
    typedef logic [2:0] tl_size_t;

    localparam tl_size_t SIZE_BYTE = 3'd0;
    localparam tl_size_t SIZE_HALF = 3'd1;
    localparam tl_size_t SIZE_WORD = 3'd2;  // Largest legal size

    // D channel param values
    localparam logic [1:0] PARAM_OK    = 2'd0;
    localparam logic [1:0] PARAM_ERROR = 2'd2;

    ////////////////////////////////////////////////////////////
    // Channel and stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        tl_opcode_t           opcode;
        logic [2:0]           param;
        tl_size_t             size;
        logic [SID_WIDTH-1:0] source;
        logic [XLEN-1:0]      address;
        logic [LANES-1:0]     mask;     // Byte enables
        logic [XLEN-1:0]      data;     // Write data, low lanes first
    } tl_a_req_t;

    typedef struct packed {
        tl_opcode_t           opcode;
        logic [1:0]           param;
        tl_size_t             size;
        logic [SID_WIDTH-1:0] source;
        logic [XLEN-1:0]      data;
        logic                 denied;
    } tl_d_rsp_t;

    // Checked request from decoder to responder
    typedef struct packed {
        logic [XLEN-1:0]      address;
        tl_size_t             size;
        logic [SID_WIDTH-1:0] source;
        logic                 is_read;  // GET, everything else writes
        logic [XLEN-1:0]      wdata;
        logic                 denied;   // Range, size or mask failure
    } mem_req_t;

    // Byte count of a transfer size
    function automatic int unsigned tl_size_bytes(input tl_size_t size);
        return 32'd1 << size;
    endfunction

endpackage

//--- hw/tl_memory_top.sv
////////////////////////////////////////////////////////////
// TileLink-UL slave memory top level
// Decoder, byte store and responder wiring
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tl_memory_top #(
    parameter int MEM_BYTES = 1024  // Memory depth in bytes
) (
    input  logic                  clk,
    input  logic                  reset,

    // A channel
    input  logic                  a_valid,
    output logic                  a_ready,
    input  tl_mem_pkg::tl_a_req_t a_req,

    // D channel
    output logic                  d_valid,
    output tl_mem_pkg::tl_d_rsp_t d_rsp,
    input  logic                  d_ready
);

    import tl_mem_pkg::*;

    // Decoder to responder
    logic            req_valid;
    mem_req_t        req;
    logic            req_take;

    // Responder to store
    logic            mem_start;
    logic            mem_write;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;
    logic            mem_done;

    tl_a_decoder #(
        .MEM_BYTES (MEM_BYTES)
    ) i_tl_a_decoder (
        .clk       (clk),
        .reset     (reset),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .a_req     (a_req),
        .req_valid (req_valid),
        .req       (req),
        .req_take  (req_take)
    );

    tl_byte_store #(
        .MEM_BYTES (MEM_BYTES)
    ) i_tl_byte_store (
        .clk       (clk),
        .reset     (reset),
        .mem_start (mem_start),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_done  (mem_done)
    );

    tl_d_responder i_tl_d_responder (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_take  (req_take),
        .mem_start (mem_start),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_done  (mem_done),
        .d_valid   (d_valid),
        .d_rsp     (d_rsp),
        .d_ready   (d_ready)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the TileLink memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tl_memory_tb \
    -Mdir obj_dir \
    -f tl_memory_top.f

sim_out="$(./obj_dir/Vtl_memory_tb)"
echo "$sim_out"

# Pass only when the testbench printed its pass line
if echo "$sim_out" | grep -q "^Simulation PASSED$"; then
    exit 0
else
    exit 1
fi

//--- tl_memory_top.f
+incdir+verification
hw/tl_mem_pkg.sv
hw/tl_a_decoder.sv
hw/tl_byte_store.sv
hw/tl_d_responder.sv
hw/tl_memory_top.sv
verification/tl_memory_tb.sv

//--- verification/tl_memory_tests.svh
////////////////////////////////////////////////////////////
// Directed tests and the reference byte model
////////////////////////////////////////////////////////////

`ifndef TL_MEMORY_TESTS_SVH
`define TL_MEMORY_TESTS_SVH

    logic [7:0] model_mem [0:MEM_BYTES-1];  // Bytes of accepted writes

    ////////////////////////////////////////////////////////////
    // Stimulus and model helpers
    ////////////////////////////////////////////////////////////

    function automatic tl_a_req_t make_req(input tl_opcode_t opcode, input tl_size_t size,
                                           input logic [XLEN-1:0] address,
                                           input logic [LANES-1:0] mask,
                                           input logic [XLEN-1:0] data);
        tl_a_req_t r;
        r.opcode    = opcode;
        r.param     = 3'd0;
        r.size      = size;
        r.source    = next_source;
        r.address   = address;
        r.mask      = mask;
        r.data      = data;
        next_source = next_source + 1'b1;
        return r;
    endfunction

    // Start address with span bytes still in range
    function automatic logic [XLEN-1:0] rand_addr(input int span);
        int unsigned r;
        r = $unsigned($random(seed));
        return XLEN'(r % (MEM_BYTES - span + 1));
    endfunction

    // Expected D beat; accepted writes land in the model here
    task automatic model_access(input tl_a_req_t r, input logic exp_denied,
                                output tl_d_rsp_t exp);
        int unsigned nbytes;
        nbytes     = 32'd1 << r.size;
        exp        = '0;
        exp.size   = r.size;
        exp.source = r.source;
        exp.param  = PARAM_OK;
        if (exp_denied) begin
            exp.opcode = ACCESS_ACK_ERROR;
            exp.param  = PARAM_ERROR;
            exp.denied = 1'b1;
        end else if (r.opcode == GET) begin
            exp.opcode = ACCESS_ACK_DATA;       // Upper lanes stay zero
            for (int k = 0; k < nbytes; k++) exp.data[8*k +: 8] = model_mem[r.address + k];
        end else begin
            exp.opcode = ACCESS_ACK;
            for (int k = 0; k < nbytes; k++) model_mem[r.address + k] = r.data[8*k +: 8];
        end
    endtask

    task automatic run_access(input tl_a_req_t r, input logic exp_denied);
        tl_d_rsp_t exp;
        tl_d_rsp_t got;
        model_access(r, exp_denied, exp);
        send_req(r);
        get_rsp(got);
        check_rsp("d_rsp", got, exp);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_ready("a_ready", a_ready, 1'b0);  // Closed during reset
            check_ready("d_valid", d_valid, 1'b0);
        end
        @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check_ready("d_valid", d_valid, 1'b0);  // Nothing offered yet
        end
        check_ready("a_ready", a_ready, 1'b1);
    endtask

    task automatic test_word_write_read();
        logic [XLEN-1:0] base;
        for (int i = 0; i < 3; i++) begin
            base = rand_addr(4);
            run_access(make_req(PUT_FULL_DATA, SIZE_WORD, base, 4'hF, $random(seed)), 1'b0);
            run_access(make_req(GET, SIZE_WORD, base, 4'hF, '0), 1'b0);
        end
    endtask

    // Byte and half writes into a known word, little-endian reads back
    task automatic test_partial_writes();
        logic [XLEN-1:0] base;
        logic [1:0]      lane;
        for (int i = 0; i < 4; i++) begin
            base = rand_addr(4);
            lane = 2'($random(seed));
            run_access(make_req(PUT_FULL_DATA, SIZE_WORD, base, 4'hF, $random(seed)), 1'b0);
            run_access(make_req(PUT_FULL_DATA, SIZE_BYTE, base + lane, 4'b0001 << lane,
                                $random(seed)), 1'b0);
            run_access(make_req(PUT_FULL_DATA, SIZE_HALF, base + {lane[1], 1'b0},
                                lane[1] ? 4'b1100 : 4'b0011, $random(seed)), 1'b0);
            run_access(make_req(GET, SIZE_WORD, base, 4'hF, '0), 1'b0);
            run_access(make_req(GET, SIZE_BYTE, base + lane, 4'b0001 << lane, '0), 1'b0);
            run_access(make_req(GET, SIZE_HALF, base + 2, 4'b1100, '0), 1'b0);
        end
    endtask

    task automatic test_illegal_masks();
        logic [XLEN-1:0] base;
        base = rand_addr(4);
        run_access(make_req(PUT_FULL_DATA, SIZE_WORD, base, 4'hF, $random(seed)), 1'b0);
        run_access(make_req(PUT_FULL_DATA, SIZE_BYTE, base, 4'b0011, $random(seed)), 1'b1);
        run_access(make_req(PUT_FULL_DATA, SIZE_HALF, base, 4'b0110, $random(seed)), 1'b1);
        run_access(make_req(PUT_FULL_DATA, SIZE_WORD, base, 4'b0111, $random(seed)), 1'b1);
        run_access(make_req(GET, SIZE_WORD, base, 4'hF, '0), 1'b0);  // Still the first word
    endtask

    task automatic test_range_limits();
        run_access(make_req(PUT_FULL_DATA, SIZE_WORD, MEM_BYTES - 3, 4'hF, $random(seed)), 1'b1);
        run_access(make_req(GET, SIZE_WORD, MEM_BYTES - 3, 4'hF, '0), 1'b1);
        run_access(make_req(GET, 3'd3, '0, 4'hF, '0), 1'b1);          // Double word
        run_access(make_req(PUT_FULL_DATA, 3'd3, '0, 4'hF, $random(seed)), 1'b1);
        run_access(make_req(PUT_FULL_DATA, SIZE_WORD, MEM_BYTES - 4, 4'hF, $random(seed)), 1'b0);
        run_access(make_req(GET, SIZE_WORD, MEM_BYTES - 4, 4'hF, '0), 1'b0);
    endtask

    // Read, write, read with D stalled and the decoder filled
    task automatic test_back_pressure();
        logic [XLEN-1:0] base;
        tl_a_req_t       r1;
        tl_a_req_t       r2;
        tl_a_req_t       r3;
        tl_d_rsp_t       e1;
        tl_d_rsp_t       e2;
        tl_d_rsp_t       e3;
        tl_d_rsp_t       got;
        int unsigned     hold;
        base = rand_addr(4);
        run_access(make_req(PUT_FULL_DATA, SIZE_WORD, base, 4'hF, $random(seed)), 1'b0);
        r1   = make_req(GET, SIZE_WORD, base, 4'hF, '0);
        r2   = make_req(PUT_FULL_DATA, SIZE_HALF, base, 4'b0011, $random(seed));
        r3   = make_req(GET, SIZE_WORD, base, 4'hF, '0);
        model_access(r1, 1'b0, e1);
        model_access(r2, 1'b0, e2);
        model_access(r3, 1'b0, e3);                 // Sees the half write
        hold = 4 + ($unsigned($random(seed)) % 12);

        @(posedge clk);
        d_ready <= 1'b0;
        send_req(r1);
        send_req(r2);                               // Waits in the decoder
        a_valid <= 1'b1;                            // Third offer, no room
        a_req   <= r3;
        @(negedge clk);
        while (!d_valid) @(negedge clk);
        check_rsp("d_rsp", d_rsp, e1);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_rsp("d_rsp", d_rsp, e1);          // Frozen under back-pressure
            check_ready("d_valid", d_valid, 1'b1);
            check_ready("a_ready", a_ready, 1'b0);
        end

        @(posedge clk);
        d_ready <= 1'b1;
        fork
            begin
                @(negedge clk);
                while (!a_ready) @(negedge clk);
                @(posedge clk);                     // Third request transfers
                a_valid <= 1'b0;
            end
            begin
                get_rsp(got);
                check_rsp("d_rsp", got, e1);
                get_rsp(got);
                check_rsp("d_rsp", got, e2);
                get_rsp(got);
                check_rsp("d_rsp", got, e3);
            end
        join
    endtask

`endif

//--- verification/tl_memory_tb.sv
////////////////////////////////////////////////////////////
// Testbench top for the TileLink-UL byte memory
// Clock, reset, DUT, A/D handshakes, compares and timeout
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tl_memory_tb;

    import tl_mem_pkg::*;

    localparam int MEM_BYTES      = 1024;
    localparam int TIMEOUT_CYCLES = 4000;  // Roughly ten times the full run

    logic      clk;
    logic      reset;
    logic      a_valid;
    logic      a_ready;
    tl_a_req_t a_req;
    logic      d_valid;
    tl_d_rsp_t d_rsp;
    logic      d_ready;

    int                   errors;
    int                   cycle_count;
    integer               seed;
    logic [SID_WIDTH-1:0] next_source;     // Rotating A source ID

    tl_memory_top #(
        .MEM_BYTES (MEM_BYTES)
    ) i_tl_memory_top (
        .clk     (clk),
        .reset   (reset),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_req   (a_req),
        .d_valid (d_valid),
        .d_rsp   (d_rsp),
        .d_ready (d_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                 // 100 ns period

    ////////////////////////////////////////////////////////////
    // Compares
    ////////////////////////////////////////////////////////////

    task automatic check_rsp(input string name, input tl_d_rsp_t got, input tl_d_rsp_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h, data %h vs %h",
                     name, got, exp, got.data, exp.data);
        end
    endtask

    // Single-bit handshake flags
    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Channel handshakes
    ////////////////////////////////////////////////////////////

    // One A beat, valid held until the transfer edge
    task automatic send_req(input tl_a_req_t r);
        @(posedge clk);
        a_valid <= 1'b1;
        a_req   <= r;
        @(negedge clk);
        while (!a_ready) @(negedge clk);   // a_ready settled mid-cycle
        @(posedge clk);                    // Transfer
        a_valid <= 1'b0;
    endtask

    // Next D beat, with d_ready already high
    task automatic get_rsp(output tl_d_rsp_t rsp);
        @(negedge clk);
        while (!d_valid) @(negedge clk);
        rsp = d_rsp;
        @(posedge clk);                    // Transfer
    endtask

    `include "tl_memory_tests.svh"

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        errors      = 0;
        seed        = 32'h5936_75da;
        next_source = '0;
        reset       <= 1'b1;               // Released inside the reset test
        a_valid     <= 1'b0;
        a_req       <= '0;
        d_ready     <= 1'b1;

        test_reset_state();
        test_word_write_read();
        test_partial_writes();
        test_illegal_masks();
        test_range_limits();
        test_back_pressure();

        repeat (4) @(posedge clk);
        $display("Tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
